// File: source/ctrl_pkg.sv
package ctrl_pkg;

    localparam int ECODE_W = 6;

    typedef logic [31:0]        addr_t;
    typedef logic [ECODE_W-1:0] ecode_t;
    typedef logic [13:0]        csr_addr_t;

    // Interrupt vector, word bits {12:11, 9:0}
    typedef logic [11:0] int_vec_t;

    // [0] PC  [1] inst buffer  [2] id  [3] dispatch  [4] ex  [5] mem  [6] wb
    typedef logic [6:0] pause_mask_t;

    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;

    localparam ecode_t EXC_NOP = 6'h3f; // No exception this cycle

    // Reset bubble, never traps
    localparam addr_t BUBBLE_PC = 32'h0000_00fc;

    typedef struct packed {
        logic [28:0] upper;
        logic        ie;
        logic [1:0]  plv;
    } crmd_view_t;

    // CSR write word, decoded by address
    typedef union packed {
        logic [31:0] raw;
        crmd_view_t  crmd;
    } csr_word_u;

    // Interrupt bits of an ECFG or ESTAT word
    function automatic int_vec_t int_vec_of(csr_word_u w);
        return {w.raw[12:11], w.raw[9:0]};
    endfunction

endpackage

// File: source/csr_forward.sv
`timescale 1ns/100ps

module csr_forward
    import ctrl_pkg::*;
(
    input  logic      wb_csr_we_i,
    input  csr_addr_t wb_csr_addr_i,
    input  csr_word_u wb_csr_wdata_i,

    input  addr_t     st_era_i,
    input  addr_t     st_eentry_i,
    input  int_vec_t  st_lie_i,
    input  int_vec_t  st_is_i,
    input  logic      st_ie_i,

    output addr_t     cur_era_o,
    output addr_t     cur_eentry_o,
    output int_vec_t  cur_lie_o,
    output int_vec_t  cur_is_o,
    output logic      cur_ie_o
);

    logic hit_crmd;
    logic hit_ecfg;
    logic hit_estat;
    logic hit_era;
    logic hit_eentry;

    // Write still in wb wins over the stored copy
    assign hit_crmd   = wb_csr_we_i && (wb_csr_addr_i == CSR_CRMD);
    assign hit_ecfg   = wb_csr_we_i && (wb_csr_addr_i == CSR_ECFG);
    assign hit_estat  = wb_csr_we_i && (wb_csr_addr_i == CSR_ESTAT);
    assign hit_era    = wb_csr_we_i && (wb_csr_addr_i == CSR_ERA);
    assign hit_eentry = wb_csr_we_i && (wb_csr_addr_i == CSR_EENTRY);

    assign cur_era_o    = hit_era    ? wb_csr_wdata_i.raw : st_era_i;
    assign cur_eentry_o = hit_eentry ? wb_csr_wdata_i.raw : st_eentry_i;
    assign cur_lie_o    = hit_ecfg   ? int_vec_of(wb_csr_wdata_i) : st_lie_i;
    assign cur_is_o     = hit_estat  ? int_vec_of(wb_csr_wdata_i) : st_is_i;
    assign cur_ie_o     = hit_crmd   ? wb_csr_wdata_i.crmd.ie : st_ie_i;

endmodule

// File: source/csr_regs.sv
`timescale 1ns/100ps

module csr_regs
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      wb_csr_we_i,
    input  csr_addr_t wb_csr_addr_i,
    input  csr_word_u wb_csr_wdata_i,

    input  logic      exc_take_i,
    input  ecode_t    exc_cause_i,
    input  addr_t     exc_pc_i,
    input  logic      ertn_i,
    input  logic [7:0] hw_int_i,

    output addr_t     st_era_o,
    output addr_t     st_eentry_o,
    output int_vec_t  st_lie_o,
    output int_vec_t  st_is_o,
    output logic      st_ie_o,
    output ecode_t    st_ecode_o
);

    logic     sw_we;
    int_vec_t is_base;
    addr_t    era_q;
    addr_t    eentry_q;
    int_vec_t lie_q;
    int_vec_t is_q;
    logic     ie_q;
    logic     pie_q;
    ecode_t   ecode_q;

    // Trap entry and return take the slot of a software write
    assign sw_we = wb_csr_we_i && !exc_take_i && !ertn_i;

    assign is_base = (sw_we && (wb_csr_addr_i == CSR_ESTAT)) ?
                     int_vec_of(wb_csr_wdata_i) : is_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            era_q    <= '0;
            eentry_q <= '0;
            lie_q    <= '0;
            is_q     <= '0;
            ie_q     <= 1'b0;
            pie_q    <= 1'b0;
            ecode_q  <= '0;
        end else begin
            is_q <= is_base | {2'b00, hw_int_i, 2'b00}; // Hardware lines land on IS[9:2]
            if (exc_take_i) begin
                era_q   <= exc_pc_i;
                ecode_q <= exc_cause_i;
                pie_q   <= ie_q;
                ie_q    <= 1'b0;
            end else if (ertn_i) begin
                ie_q <= pie_q;
            end else if (sw_we) begin
                case (wb_csr_addr_i)
                    CSR_CRMD:   ie_q     <= wb_csr_wdata_i.crmd.ie;
                    CSR_ECFG:   lie_q    <= int_vec_of(wb_csr_wdata_i);
                    CSR_ERA:    era_q    <= wb_csr_wdata_i.raw;
                    CSR_EENTRY: eentry_q <= wb_csr_wdata_i.raw;
                    default: ; // ESTAT handled above
                endcase
            end
        end
    end

    assign st_era_o    = era_q;
    assign st_eentry_o = eentry_q;
    assign st_lie_o    = lie_q;
    assign st_is_o     = is_q;
    assign st_ie_o     = ie_q;
    assign st_ecode_o  = ecode_q;

endmodule

// File: source/exception_arbiter.sv
`timescale 1ns/100ps

module exception_arbiter
    import ctrl_pkg::*;
#(
    parameter int NUM_EXC_SRC = 6
) (
    input  addr_t                          mem_pc_i,
    input  logic [NUM_EXC_SRC-1:0]         mem_exc_valid_i,
    input  logic [NUM_EXC_SRC*ECODE_W-1:0] mem_exc_cause_i,
    input  logic                           mem_is_ertn_i,

    input  addr_t                          cur_era_i,
    input  addr_t                          cur_eentry_i,
    input  int_vec_t                       cur_lie_i,
    input  int_vec_t                       cur_is_i,
    input  logic                           cur_ie_i,

    output logic                           exc_take_o,
    output ecode_t                         exc_cause_o,
    output logic                           flush_o,
    output addr_t                          new_pc_o,
    output logic                           int_pending_o
);

    logic     any_valid;
    ecode_t   picked;
    int_vec_t int_vec;

    assign any_valid = |mem_exc_valid_i;

    // Higher index overrides, so the last valid source wins
    always_comb begin
        picked = EXC_NOP;
        for (int i = 0; i < NUM_EXC_SRC; i++) begin
            if (mem_exc_valid_i[i]) begin
                picked = mem_exc_cause_i[i*ECODE_W +: ECODE_W];
            end
        end
    end

    assign exc_take_o  = any_valid && (mem_pc_i != BUBBLE_PC);
    assign exc_cause_o = exc_take_o ? picked : EXC_NOP;

    assign flush_o  = any_valid || mem_is_ertn_i;
    assign new_pc_o = mem_is_ertn_i ? cur_era_i : cur_eentry_i;

    // Enabled and pending lines, masked by global IE
    assign int_vec       = cur_ie_i ? (cur_lie_i & cur_is_i) : '0;
    assign int_pending_o = |int_vec;

endmodule

// File: source/pause_ctrl.sv
`timescale 1ns/100ps

module pause_ctrl
    import ctrl_pkg::*;
(
    input  logic        pause_if_i,
    input  logic        pause_id_i,
    input  logic        pause_dispatch_i,
    input  logic        pause_ex_i,
    input  logic        pause_mem_i,
    input  logic        mem_is_idle_i,
    input  logic        continue_idle_i,
    input  logic        int_pending_i,
    output pause_mask_t pause_o,
    output logic        send_inst1_en_o
);

    logic idle_wait;

    // IDLE holds mem until an interrupt or a wake request
    assign idle_wait = mem_is_idle_i && !int_pending_i && !continue_idle_i;

    always_comb begin
        if (pause_if_i) begin
            pause_o = 7'b0000001;
        end else if (pause_id_i) begin
            pause_o = 7'b0000111;
        end else if (pause_dispatch_i) begin
            pause_o = 7'b0001111;
        end else if (pause_ex_i) begin
            pause_o = 7'b0011111;
        end else if (pause_mem_i || idle_wait) begin
            pause_o = 7'b0111111;
        end else begin
            pause_o = '0;
        end
    end

    assign send_inst1_en_o = !pause_o[1];

endmodule

// File: source/exc_ctrl_top.sv
`timescale 1ns/100ps

module exc_ctrl_top
    import ctrl_pkg::*;
#(
    parameter int NUM_EXC_SRC = 6
) (
    input  logic                           clk,
    input  logic                           arst_n_i,

    input  logic                           wb_csr_we_i,
    input  csr_addr_t                      wb_csr_addr_i,
    input  csr_word_u                      wb_csr_wdata_i,

    input  addr_t                          mem_pc_i,
    input  logic [NUM_EXC_SRC-1:0]         mem_exc_valid_i,
    input  logic [NUM_EXC_SRC*ECODE_W-1:0] mem_exc_cause_i,
    input  logic                           mem_is_ertn_i,
    input  logic                           mem_is_idle_i,

    input  logic                           pause_if_i,
    input  logic                           pause_id_i,
    input  logic                           pause_dispatch_i,
    input  logic                           pause_ex_i,
    input  logic                           pause_mem_i,
    input  logic                           continue_idle_i,
    input  logic [7:0]                     hw_int_i,

    output logic                           flush_o,
    output addr_t                          new_pc_o,
    output logic                           is_interrupt_o,
    output ecode_t                         exc_cause_o,
    output pause_mask_t                    pause_o,
    output logic                           send_inst1_en_o,
    output ecode_t                         ecode_o
);

    addr_t    st_era;
    addr_t    st_eentry;
    int_vec_t st_lie;
    int_vec_t st_is;
    logic     st_ie;
    addr_t    cur_era;
    addr_t    cur_eentry;
    int_vec_t cur_lie;
    int_vec_t cur_is;
    logic     cur_ie;
    logic     exc_take;

    csr_forward u_csr_forward (
        .wb_csr_we_i    (wb_csr_we_i),
        .wb_csr_addr_i  (wb_csr_addr_i),
        .wb_csr_wdata_i (wb_csr_wdata_i),
        .st_era_i       (st_era),
        .st_eentry_i    (st_eentry),
        .st_lie_i       (st_lie),
        .st_is_i        (st_is),
        .st_ie_i        (st_ie),
        .cur_era_o      (cur_era),
        .cur_eentry_o   (cur_eentry),
        .cur_lie_o      (cur_lie),
        .cur_is_o       (cur_is),
        .cur_ie_o       (cur_ie)
    );

    exception_arbiter #(
        .NUM_EXC_SRC (NUM_EXC_SRC)
    ) u_exception_arbiter (
        .mem_pc_i        (mem_pc_i),
        .mem_exc_valid_i (mem_exc_valid_i),
        .mem_exc_cause_i (mem_exc_cause_i),
        .mem_is_ertn_i   (mem_is_ertn_i),
        .cur_era_i       (cur_era),
        .cur_eentry_i    (cur_eentry),
        .cur_lie_i       (cur_lie),
        .cur_is_i        (cur_is),
        .cur_ie_i        (cur_ie),
        .exc_take_o      (exc_take),
        .exc_cause_o     (exc_cause_o),
        .flush_o         (flush_o),
        .new_pc_o        (new_pc_o),
        .int_pending_o   (is_interrupt_o)
    );

    // Trap state lands one edge after the strobe
    csr_regs u_csr_regs (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .wb_csr_we_i    (wb_csr_we_i),
        .wb_csr_addr_i  (wb_csr_addr_i),
        .wb_csr_wdata_i (wb_csr_wdata_i),
        .exc_take_i     (exc_take),
        .exc_cause_i    (exc_cause_o),
        .exc_pc_i       (mem_pc_i),
        .ertn_i         (mem_is_ertn_i),
        .hw_int_i       (hw_int_i),
        .st_era_o       (st_era),
        .st_eentry_o    (st_eentry),
        .st_lie_o       (st_lie),
        .st_is_o        (st_is),
        .st_ie_o        (st_ie),
        .st_ecode_o     (ecode_o)
    );

    pause_ctrl u_pause_ctrl (
        .pause_if_i       (pause_if_i),
        .pause_id_i       (pause_id_i),
        .pause_dispatch_i (pause_dispatch_i),
        .pause_ex_i       (pause_ex_i),
        .pause_mem_i      (pause_mem_i),
        .mem_is_idle_i    (mem_is_idle_i),
        .continue_idle_i  (continue_idle_i),
        .int_pending_i    (is_interrupt_o),
        .pause_o          (pause_o),
        .send_inst1_en_o  (send_inst1_en_o)
    );

endmodule

// File: verif/exc_ctrl_props.sv
`timescale 1ns/100ps

module exc_ctrl_props
    import ctrl_pkg::*;
#(
    parameter int NUM_EXC_SRC = 6
) (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic [NUM_EXC_SRC-1:0] mem_exc_valid_i,
    input logic                   flush_o,
    input pause_mask_t            pause_o,
    input logic                   exc_take,
    input ecode_t                 exc_cause_o,
    input ecode_t                 ecode_o
);

    int fail_count = 0;

    // Flush even at the bubble PC
    flush_on_exc: assert property (@(posedge clk) disable iff (!arst_n_i)
        |mem_exc_valid_i |-> flush_o)
        else begin
            $error("flush_o low while an exception source is valid");
            fail_count++;
        end

    pause_legal: assert property (@(posedge clk) disable iff (!arst_n_i)
        pause_o inside {7'h00, 7'h01, 7'h07, 7'h0f, 7'h1f, 7'h3f})
        else begin
            $error("pause_o holds a mask outside the legal set");
            fail_count++;
        end

    ecode_saved: assert property (@(posedge clk) disable iff (!arst_n_i)
        exc_take |=> (ecode_o == $past(exc_cause_o)))
        else begin
            $error("ecode_o does not hold the cause of the taken exception");
            fail_count++;
        end

endmodule

bind exc_ctrl_top exc_ctrl_props #(
    .NUM_EXC_SRC (NUM_EXC_SRC)
) u_props (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .mem_exc_valid_i (mem_exc_valid_i),
    .flush_o         (flush_o),
    .pause_o         (pause_o),
    .exc_take        (exc_take),
    .exc_cause_o     (exc_cause_o),
    .ecode_o         (ecode_o)
);

// File: verif/exc_ctrl_tb.sv
`timescale 1ns/100ps

module exc_ctrl_tb
    import ctrl_pkg::*;
();

    localparam int NSRC       = 6;
    localparam int RST_CYCLES = 16;
    localparam int NFIELDS    = 18;

    logic                    clk;
    logic                    arst_n_i;
    logic                    wb_csr_we_i;
    csr_addr_t               wb_csr_addr_i;
    csr_word_u               wb_csr_wdata_i;
    addr_t                   mem_pc_i;
    logic [NSRC-1:0]         mem_exc_valid_i;
    logic [NSRC*ECODE_W-1:0] mem_exc_cause_i;
    logic                    mem_is_ertn_i;
    logic                    mem_is_idle_i;
    logic                    pause_if_i;
    logic                    pause_id_i;
    logic                    pause_dispatch_i;
    logic                    pause_ex_i;
    logic                    pause_mem_i;
    logic                    continue_idle_i;
    logic [7:0]              hw_int_i;
    logic                    flush_o;
    addr_t                   new_pc_o;
    logic                    is_interrupt_o;
    ecode_t                  exc_cause_o;
    pause_mask_t             pause_o;
    logic                    send_inst1_en_o;
    ecode_t                  ecode_o;

    string       vectors[$];
    logic [63:0] f [NFIELDS]; // Fields of the current vector line
    int          mismatches = 0;
    int          other_errs = 0;
    int          cycles     = 0;
    int          limit      = 0;
    int          vec_idx    = 0;

    exc_ctrl_top #(.NUM_EXC_SRC(NSRC)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the vectors did not finish", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%h expected 0x%h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic check_pc(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%h expected 0x%h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic check_cause(input string name, input ecode_t got, input ecode_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%h expected 0x%h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic check_pause(input string name, input pause_mask_t got, input pause_mask_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%h expected 0x%h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic drive_vector();
        wb_csr_we_i     <= f[0][0];
        wb_csr_addr_i   <= f[1][13:0];
        wb_csr_wdata_i  <= f[2][31:0];
        mem_pc_i        <= f[3][31:0];
        mem_exc_valid_i <= f[4][NSRC-1:0];
        mem_exc_cause_i <= f[5][NSRC*ECODE_W-1:0];
        mem_is_ertn_i   <= f[6][0];
        mem_is_idle_i   <= f[7][0];
        {pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i} <= f[8][4:0];
        continue_idle_i <= f[9][0];
        hw_int_i        <= f[10][7:0];
    endtask

    task automatic check_outputs();
        check_bit("flush_o", flush_o, f[11][0]);
        check_pc("new_pc_o", new_pc_o, f[12][31:0]);
        check_bit("is_interrupt_o", is_interrupt_o, f[13][0]);
        check_cause("exc_cause_o", exc_cause_o, f[14][ECODE_W-1:0]);
        check_pause("pause_o", pause_o, f[15][6:0]);
        check_bit("send_inst1_en_o", send_inst1_en_o, f[16][0]);
        check_cause("ecode_o", ecode_o, f[17][ECODE_W-1:0]);
    endtask

    task automatic read_vectors();
        int    fd;
        string line;
        fd = $fopen("verif/exc_ctrl_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/exc_ctrl_tests.txt for reading");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() > 1 && line.getc(0) != "#") vectors.push_back(line); // Skip notes
        end
        $fclose(fd);
    endtask

    initial begin
        int n;
        int assert_fails;
        foreach (f[i]) f[i] = '0;
        arst_n_i <= 1'b0;
        drive_vector();
        read_vectors();
        if (vectors.size() == 0 && other_errs == 0) begin
            $display("The tests file holds no vectors");
            other_errs++;
        end
        limit = RST_CYCLES + vectors.size() + 20;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int v = 0; v < vectors.size(); v++) begin
            vec_idx = v + 1;
            n = $sscanf(vectors[v], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (n != NFIELDS) begin
                $display("Vector %0d is malformed, only %0d of %0d fields read", vec_idx, n, NFIELDS);
                other_errs++;
                continue;
            end
            @(posedge clk);
            drive_vector();
            @(negedge clk); // Outputs settled, away from the drive edge
            check_outputs();
        end
        assert_fails = dut0.u_props.fail_count;
        $display("Errors: %0d mismatches, %0d assertion failures, %0d other",
                 mismatches, assert_fails, other_errs);
        if (mismatches == 0 && other_errs == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verif/exc_ctrl_tests.txt
# Inputs we addr wdata pc valid causes ertn idle preq(if id dis ex mem) cont hw_int
# Then expected flush new_pc intr exc_cause pause send_en ecode, every column in hex
1 00c 1c000800 1c000000 00 38d30b289 0 0 10 0 00  0 1c000800 0 3f 01 1 00
0 000 00000000 1c000000 00 38d30b289 0 0 08 0 00  0 1c000800 0 3f 07 0 00
1 000 00000004 1c000000 00 38d30b289 0 0 04 0 00  0 1c000800 0 3f 0f 0 00
1 004 00000004 1c000000 00 38d30b289 0 0 02 0 00  0 1c000800 0 3f 1f 0 00
0 000 00000000 1c000000 00 38d30b289 0 0 01 0 01  0 1c000800 0 3f 3f 0 00
0 000 00000000 1c000000 00 38d30b289 0 1 00 0 00  0 1c000800 1 3f 00 1 00
1 004 00000000 1c000000 00 38d30b289 0 1 00 0 00  0 1c000800 0 3f 3f 0 00
1 004 00000004 1c000000 00 38d30b289 0 0 00 0 00  0 1c000800 1 3f 00 1 00
1 000 00000000 1c000000 00 38d30b289 0 0 0f 0 00  0 1c000800 0 3f 07 0 00
1 000 00000004 1c000000 00 38d30b289 0 0 00 0 00  0 1c000800 1 3f 00 1 00
0 000 00000000 1c001000 0c 38d30b289 0 0 00 0 00  1 1c000800 1 0c 00 1 00
0 000 00000000 1c000000 00 38d30b289 0 1 00 0 00  0 1c000800 0 3f 3f 0 0c
0 000 00000000 000000fc 3f 38d30b289 0 1 00 1 00  1 1c000800 0 3f 00 1 0c
0 000 00000000 1c000000 00 38d30b289 1 0 00 0 00  1 1c001000 0 3f 00 1 0c
0 000 00000000 1c000000 00 38d30b289 0 0 00 0 00  0 1c000800 1 3f 00 1 0c
1 005 00000000 1c000000 00 38d30b289 0 0 11 0 00  0 1c000800 0 3f 01 1 0c
0 000 00000000 1c002000 13 38d30b289 0 0 03 0 00  1 1c000800 0 0d 1f 0 0c
1 006 1c003000 1c000000 00 38d30b289 0 0 06 0 00  0 1c000800 0 3f 0f 0 0d
0 000 00000000 1c000000 00 38d30b289 1 0 00 0 00  1 1c003000 0 3f 00 1 0d
0 000 00000000 1c000000 00 38d30b289 0 0 00 0 80  0 1c000800 0 3f 00 1 0d
1 004 00000200 1c000000 00 38d30b289 0 0 00 0 00  0 1c000800 1 3f 00 1 0d
1 005 00001000 1c000000 00 38d30b289 0 1 00 0 00  0 1c000800 0 3f 3f 0 0d

// File: build.f
source/ctrl_pkg.sv
source/csr_forward.sv
source/csr_regs.sv
source/exception_arbiter.sv
source/pause_ctrl.sv
source/exc_ctrl_top.sv
verif/exc_ctrl_props.sv
verif/exc_ctrl_tb.sv

// File: Bender.yml
package:
  name: exc_ctrl

sources:
  - files:
      - source/ctrl_pkg.sv
      - source/csr_forward.sv
      - source/csr_regs.sv
      - source/exception_arbiter.sv
      - source/pause_ctrl.sv
      - source/exc_ctrl_top.sv
  - target: test
    files:
      - verif/exc_ctrl_props.sv
      - verif/exc_ctrl_tb.sv
